// File: nx_aggregator.sv
// Column output aggregator
// Captures output state, forwards all other traffic

`timescale 1ns/1ps
`default_nettype none

module nx_aggregator #(
      parameter int COLUMN = 0
) (
      input  logic                                          i_clk
    , input  logic                                          i_rst_n
    // Messages from this column of the mesh
    , input  nx_message_pkg::node_message_t                 i_inbound_data
    , input  logic                                          i_inbound_valid
    , output logic                                          o_inbound_ready
    // Messages from the previous aggregator
    , input  nx_message_pkg::node_message_t                 i_passthrough_data
    , input  logic                                          i_passthrough_valid
    , output logic                                          o_passthrough_ready
    // Merged forwarding stream
    , output nx_message_pkg::node_message_t                 o_outbound_data
    , output logic                                          o_outbound_valid
    , input  logic                                          i_outbound_ready
    // Captured output state
    , output logic [nx_constants_pkg::AGG_OUTPUTS-1:0]      o_outputs
    , output logic                                          o_idle
);

    // ==========================================================
    // Signals
    // ==========================================================

    // Column this aggregator answers to
    logic [nx_constants_pkg::COLUMN_WIDTH-1:0]       column_id;

    // Output message detect and slot decode
    logic                                            is_output;
    logic [nx_constants_pkg::SLOTS-1:0]              slot_hit;

    // Output state, one byte per slot
    logic [nx_constants_pkg::SLOTS-1:0][nx_constants_pkg::SLOT_WIDTH-1:0] slots_q;

    // Arbiter inputs, 0 from the column, 1 from the chain
    nx_message_pkg::node_message_t [1:0]             comb_data;
    logic [1:0]                                      comb_valid;
    logic [1:0]                                      comb_ready;

    // ==========================================================
    // Output message detect
    // ==========================================================

    assign column_id = COLUMN[nx_constants_pkg::COLUMN_WIDTH-1:0];

    // Row not compared
    // anything travelling down this column is captured
    assign is_output = i_inbound_valid
                    && (i_inbound_data.aggout.header.target.column == column_id)
                    && (i_inbound_data.aggout.header.command
                        == nx_constants_pkg::NODE_COMMAND_SIGNAL)
                    && !i_inbound_data.aggout.bypass;

    // One-hot slot select, empty when no capture
    always_comb begin
        slot_hit = '0;
        slot_hit[i_inbound_data.aggout.slot] = is_output;
    end

    // ==========================================================
    // Output state
    // ==========================================================

    // Masked merge into the addressed slot
    for (genvar idx = 0; idx < nx_constants_pkg::SLOTS; idx++) begin : gen_slot
        always_ff @(posedge i_clk) begin
            if (!i_rst_n) begin
                slots_q[idx] <= '0;
            end else if (slot_hit[idx]) begin
                slots_q[idx] <= (i_inbound_data.aggout.data & i_inbound_data.aggout.mask)
                              | (slots_q[idx] & ~i_inbound_data.aggout.mask);
            end
        end
    end

    // Slot 0 in the low byte
    assign o_outputs = slots_q;

    // ==========================================================
    // Forwarding merge
    // ==========================================================

    // Non-output column traffic
    assign comb_data[0]  = i_inbound_data;
    assign comb_valid[0] = i_inbound_valid && !is_output;

    // Output messages never stall
    assign o_inbound_ready = is_output || comb_ready[0];

    // Upstream chain traffic
    assign comb_data[1]        = i_passthrough_data;
    assign comb_valid[1]       = i_passthrough_valid;
    assign o_passthrough_ready = comb_ready[1];

    nx_stream_arbiter u_arbiter (
          .i_clk            ( i_clk            )
        , .i_rst_n          ( i_rst_n          )
        , .i_inbound_data   ( comb_data        )
        , .i_inbound_valid  ( comb_valid       )
        , .o_inbound_ready  ( comb_ready       )
        , .o_outbound_data  ( o_outbound_data  )
        , .o_outbound_valid ( o_outbound_valid )
        , .i_outbound_ready ( i_outbound_ready )
    );

    // ==========================================================
    // Idle
    // ==========================================================

    // Nothing arriving, nothing held
    assign o_idle = !i_inbound_valid && !i_passthrough_valid && !o_outbound_valid;

endmodule : nx_aggregator

`default_nettype wire

// File: nx_aggregator_chain.f
nx_constants_pkg.sv
nx_message_pkg.sv
nx_stream_arbiter.sv
nx_aggregator.sv
nx_aggregator_chain.sv
nx_aggregator_checker.sv
tb_nx_aggregator_chain.sv

// File: nx_aggregator_chain.sv
// Aggregator chain
// Bottom row of the mesh, neighbour input to host output

`timescale 1ns/1ps
`default_nettype none

module nx_aggregator_chain (
      input  logic                              i_clk
    , input  logic                              i_rst_n
    // Per-column inbound streams
    , input  nx_message_pkg::node_message_t [nx_constants_pkg::COLUMNS-1:0] i_column_data
    , input  logic [nx_constants_pkg::COLUMNS-1:0]                         i_column_valid
    , output logic [nx_constants_pkg::COLUMNS-1:0]                         o_column_ready
    // From the neighbouring chain
    , input  nx_message_pkg::node_message_t     i_chain_data
    , input  logic                              i_chain_valid
    , output logic                              o_chain_ready
    // Towards the host
    , output nx_message_pkg::node_message_t     o_host_data
    , output logic                              o_host_valid
    , input  logic                              i_host_ready
    // Output state, column k in field k
    , output logic [nx_constants_pkg::COLUMNS*nx_constants_pkg::AGG_OUTPUTS-1:0] o_outputs
    , output logic                              o_idle
);

    // ==========================================================
    // Chain links
    // ==========================================================

    // Link k feeds aggregator k
    // last link leaves for the host
    nx_message_pkg::node_message_t [nx_constants_pkg::COLUMNS:0] link_data;
    logic [nx_constants_pkg::COLUMNS:0]                          link_valid;
    logic [nx_constants_pkg::COLUMNS:0]                          link_ready;

    // Per-aggregator idle flags
    logic [nx_constants_pkg::COLUMNS-1:0]                        column_idle;

    // Head of the chain
    assign link_data[0]  = i_chain_data;
    assign link_valid[0] = i_chain_valid;
    assign o_chain_ready = link_ready[0];

    // Tail of the chain
    assign o_host_data  = link_data[nx_constants_pkg::COLUMNS];
    assign o_host_valid = link_valid[nx_constants_pkg::COLUMNS];
    assign link_ready[nx_constants_pkg::COLUMNS] = i_host_ready;

    // ==========================================================
    // Aggregators
    // ==========================================================

    for (genvar col = 0; col < nx_constants_pkg::COLUMNS; col++) begin : gen_column
        nx_aggregator #(
              .COLUMN              ( col                      )
        ) u_aggregator (
              .i_clk               ( i_clk                    )
            , .i_rst_n             ( i_rst_n                  )
            // Own column
            , .i_inbound_data      ( i_column_data[col]       )
            , .i_inbound_valid     ( i_column_valid[col]      )
            , .o_inbound_ready     ( o_column_ready[col]      )
            // Previous link
            , .i_passthrough_data  ( link_data[col]           )
            , .i_passthrough_valid ( link_valid[col]          )
            , .o_passthrough_ready ( link_ready[col]          )
            // Next link
            , .o_outbound_data     ( link_data[col+1]         )
            , .o_outbound_valid    ( link_valid[col+1]        )
            , .i_outbound_ready    ( link_ready[col+1]        )
            // State
            , .o_outputs           ( o_outputs[col*nx_constants_pkg::AGG_OUTPUTS +:
                                               nx_constants_pkg::AGG_OUTPUTS] )
            , .o_idle              ( column_idle[col]         )
        );
    end

    // ==========================================================
    // Idle
    // ==========================================================

    // Idle only when every stage is idle
    assign o_idle = &column_idle;

endmodule : nx_aggregator_chain

`default_nettype wire

// File: nx_aggregator_checker.sv
// Aggregator assertions
// Stream hold, state update, idle and reset rules

`timescale 1ns/1ps
`default_nettype none

module nx_aggregator_checker (
      input logic                                     i_clk
    , input logic                                     i_rst_n
    , input nx_message_pkg::node_message_t            i_outbound_data
    , input logic                                     i_outbound_valid
    , input logic                                     i_outbound_ready
    , input logic [nx_constants_pkg::AGG_OUTPUTS-1:0] i_outputs
    , input logic                                     i_idle
    , input logic                                     i_capture
);

    // Failed assertions in this instance
    int failures = 0;

    // ==========================================================
    // Stream rules
    // ==========================================================

    // Stalled outbound word stays put
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_outbound_valid && !i_outbound_ready |=> i_outbound_valid && $stable(i_outbound_data))
    else begin
        $error("outbound stream dropped or changed while stalled");
        failures++;
    end

    // An idle stage has nothing to emit next cycle
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_idle |=> !i_outbound_valid)
    else begin
        $error("outbound word appeared after an idle cycle");
        failures++;
    end

    // ==========================================================
    // State rules
    // ==========================================================

    // Output state moves only after a captured message
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) && (i_outputs != $past(i_outputs)) |-> $past(i_capture))
    else begin
        $error("output state changed without a captured message");
        failures++;
    end

    // Leaving reset with an empty output stage
    assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_outbound_valid)
    else begin
        $error("outbound valid high right after reset");
        failures++;
    end

endmodule : nx_aggregator_checker

`default_nettype wire

// File: nx_aggregator_patterns.txt
# src 0-3 column, 4 chain; word message hex; stall host ready low cycles
# kind C capture with col, slot and expected slot hex; kind F forward, rest unused
0 002297FC 0 C 0 0 A5
1 00A8F3C0 0 C 1 2 30
2 0127FC3C 0 C 2 1 0F
3 01AE07FC 0 C 3 3 81
0 0021683C 0 C 0 0 AA
1 00A83030 0 C 1 2 3C
2 2925C3C0 0 C 2 1 7F
3 49A04BFC 0 C 3 0 12
0 0033FFFC 2 F 0 0 00
1 00C447FC 0 F 0 0 00
2 01A08BFC 3 F 0 0 00
3 00015400 0 F 0 0 00
4 00A0CFFC 0 F 0 0 00
4 00619800 5 F 0 0 00
0 0121DFFC 0 F 0 0 00
4 01400401 6 F 0 0 00
1 00E00800 0 F 0 0 00
4 01800C00 5 F 0 0 00
3 01C01000 0 F 0 0 00
4 01E01400 8 F 0 0 00
2 01301BFC 0 F 0 0 00
1 00AD10F0 0 C 1 3 04
4 00401C00 4 F 0 0 00
0 00A023FC 0 F 0 0 00
0 00270F00 0 C 0 1 C0
4 01602800 0 F 0 0 00

// File: nx_constants_pkg.sv
// Mesh constants
// Sizes, command codes and node identifiers

`default_nettype none

package nx_constants_pkg;

    // ==========================================================
    // Node addressing
    // ==========================================================

    // Row and column fields of a node address
    localparam int ROW_WIDTH    = 4;
    localparam int COLUMN_WIDTH = 4;

    // Width of the command field
    localparam int COMMAND_WIDTH = 2;

    // ==========================================================
    // Aggregator sizing
    // ==========================================================

    // One aggregator per mesh column
    localparam int COLUMNS = 4;

    // Output state held by each aggregator
    localparam int AGG_OUTPUTS      = 32;
    localparam int SLOT_WIDTH       = 8;
    localparam int SLOTS            = 4;
    localparam int SLOT_INDEX_WIDTH = 2;

    // Full message word
    localparam int MESSAGE_WIDTH = 31;

    // ==========================================================
    // Types
    // ==========================================================

    // Message commands
    typedef enum logic [COMMAND_WIDTH-1:0] {
        NODE_COMMAND_LOAD    = 2'd0,
        NODE_COMMAND_SIGNAL  = 2'd1,
        NODE_COMMAND_CONTROL = 2'd2,
        NODE_COMMAND_TRACE   = 2'd3
    } node_command_t;

    // Node address, row above column
    typedef struct packed {
        logic [ROW_WIDTH-1:0]    row;
        logic [COLUMN_WIDTH-1:0] column;
    } node_id_t;

endpackage : nx_constants_pkg

`default_nettype wire

// File: nx_message_pkg.sv
// Mesh message formats
// Header, routing view and output-state view of a message

`default_nettype none

package nx_message_pkg;

    // ==========================================================
    // Field widths
    // ==========================================================

    // Header is target address plus command
    localparam int HEADER_WIDTH = nx_constants_pkg::ROW_WIDTH
                                + nx_constants_pkg::COLUMN_WIDTH
                                + nx_constants_pkg::COMMAND_WIDTH;

    // Everything below the header
    localparam int PAYLOAD_WIDTH = nx_constants_pkg::MESSAGE_WIDTH - HEADER_WIDTH;

    // Unused tail of an output message
    localparam int SPARE_WIDTH = PAYLOAD_WIDTH
                               - 1
                               - nx_constants_pkg::SLOT_INDEX_WIDTH
                               - (2 * nx_constants_pkg::SLOT_WIDTH);

    // ==========================================================
    // Message header
    // ==========================================================

    typedef struct packed {
        nx_constants_pkg::node_id_t      target;
        nx_constants_pkg::node_command_t command;
    } node_header_t;

    // ==========================================================
    // Message decodings
    // ==========================================================

    // Routing view, payload left opaque
    typedef struct packed {
        node_header_t               header;
        logic [PAYLOAD_WIDTH-1:0]   payload;
    } node_raw_t;

    // Output-state view, a SIGNAL message bound for an aggregator
    typedef struct packed {
        node_header_t                                  header;
        logic                                          bypass;
        logic [nx_constants_pkg::SLOT_INDEX_WIDTH-1:0] slot;
        logic [nx_constants_pkg::SLOT_WIDTH-1:0]       data;
        logic [nx_constants_pkg::SLOT_WIDTH-1:0]       mask;
        logic [SPARE_WIDTH-1:0]                        spare;
    } node_aggout_t;

    // One word, two decodings
    typedef union packed {
        node_raw_t    raw;
        node_aggout_t aggout;
    } node_message_t;

endpackage : nx_message_pkg

`default_nettype wire

// File: nx_stream_arbiter.sv
// Two-way round-robin stream merge
// Single registered output stage

`timescale 1ns/1ps
`default_nettype none

module nx_stream_arbiter (
      input  logic                                i_clk
    , input  logic                                i_rst_n
    // Inbound streams, index 0 and 1
    , input  nx_message_pkg::node_message_t [1:0] i_inbound_data
    , input  logic [1:0]                          i_inbound_valid
    , output logic [1:0]                          o_inbound_ready
    // Merged outbound stream
    , output nx_message_pkg::node_message_t       o_outbound_data
    , output logic                                o_outbound_valid
    , input  logic                                i_outbound_ready
);

    // ==========================================================
    // Signals
    // ==========================================================

    // Output register
    nx_message_pkg::node_message_t out_data_q;
    logic                          out_valid_q;

    // Round-robin pointer, the input that wins a tie
    logic                          pointer_q;

    // Arbitration
    logic                          can_load;
    logic                          select;
    logic [1:0]                    grant;
    logic                          load;

    // ==========================================================
    // Arbitration
    // ==========================================================

    // Register free, or emptied this cycle
    assign can_load = !out_valid_q || i_outbound_ready;

    // Tie goes to the pointer
    // otherwise whichever input is valid
    always_comb begin
        if (i_inbound_valid[0] && i_inbound_valid[1]) begin
            select = pointer_q;
        end else begin
            select = i_inbound_valid[1];
        end
    end

    // One-hot grant, only for a valid input
    assign grant[0] = i_inbound_valid[0] && (select == 1'b0);
    assign grant[1] = i_inbound_valid[1] && (select == 1'b1);

    // Both inputs stalled under back-pressure
    assign o_inbound_ready = grant & {2{can_load}};

    // A transfer into the output register
    assign load = |o_inbound_ready;

    // ==========================================================
    // Pointer
    // ==========================================================

    // Move past the winner on each accepted input
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pointer_q <= 1'b0;
        end else if (load) begin
            pointer_q <= ~select;
        end
    end

    // ==========================================================
    // Output register
    // ==========================================================

    // Valid bit, cleared by reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            out_valid_q <= 1'b0;
        end else if (can_load) begin
            // Refill or drain
            out_valid_q <= load;
        end
    end

    // Payload, held while stalled
    always_ff @(posedge i_clk) begin
        if (load) begin
            out_data_q <= i_inbound_data[select];
        end
    end

    assign o_outbound_data  = out_data_q;
    assign o_outbound_valid = out_valid_q;

endmodule : nx_stream_arbiter

`default_nettype wire

// File: tb_nx_aggregator_chain.sv
// Aggregator chain testbench
// Pattern-driven, output model and per-source scoreboard

`timescale 1ns/1ps
`default_nettype none

module tb_nx_aggregator_chain;

    localparam int WAIT_LIMIT = 400;

    // ==========================================================
    // DUT signals
    // ==========================================================

    logic             clk;
    logic             rst_n;
    logic [3:0][30:0] column_data;
    logic [3:0]       column_valid;
    logic [3:0]       column_ready;
    logic [30:0]      chain_data;
    logic             chain_valid;
    logic             chain_ready;
    logic [30:0]      host_data;
    logic             host_valid;
    logic             host_ready = 1'b1;
    logic [127:0]     outputs;
    logic             idle;

    // Model, column k slot s
    logic [3:0][3:0][7:0] model = '0;
    // Forwarded words per source, 4 is the chain input
    logic [30:0]      pending [5][$];
    int               cycle_count = 0;
    int               stall_until = 0;
    int               checks = 0;
    int               value_errors = 0;
    int               other_errors = 0;
    int               assertion_errors;

    nx_aggregator_chain UUT (
          .i_clk          ( clk          )
        , .i_rst_n        ( rst_n        )
        , .i_column_data  ( column_data  )
        , .i_column_valid ( column_valid )
        , .o_column_ready ( column_ready )
        , .i_chain_data   ( chain_data   )
        , .i_chain_valid  ( chain_valid  )
        , .o_chain_ready  ( chain_ready  )
        , .o_host_data    ( host_data    )
        , .o_host_valid   ( host_valid   )
        , .i_host_ready   ( host_ready   )
        , .o_outputs      ( outputs      )
        , .o_idle         ( idle         )
    );

    bind nx_aggregator nx_aggregator_checker u_checker (
          .i_clk            ( i_clk            )
        , .i_rst_n          ( i_rst_n          )
        , .i_outbound_data  ( o_outbound_data  )
        , .i_outbound_valid ( o_outbound_valid )
        , .i_outbound_ready ( i_outbound_ready )
        , .i_outputs        ( o_outputs        )
        , .i_idle           ( o_idle           )
        , .i_capture        ( is_output        )
    );

    // ==========================================================
    // Clock, host back-pressure, host monitor
    // ==========================================================

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Host ready low until the stall window ends
    always @(posedge clk) begin
        #1;
        host_ready <= (cycle_count >= stall_until);
    end

    // Word leaves at the next edge
    always @(negedge clk) begin
        if (rst_n && host_valid && host_ready) begin
            take_host_word(host_data);
        end
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            value_errors++;
            $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    // Must match the oldest word of some source
    task automatic take_host_word(input logic [30:0] word);
        bit found;
        found = 1'b0;
        for (int src = 0; src < 5; src++) begin
            if (!found && pending[src].size() > 0 && pending[src][0] == word) begin
                void'(pending[src].pop_front());
                found = 1'b1;
            end
        end
        if (!found) begin
            other_errors++;
            $display("host word %h is not the oldest pending word of any source", word);
        end
    endtask

    function automatic int pending_total();
        int total;
        total = 0;
        for (int src = 0; src < 5; src++) begin
            total += pending[src].size();
        end
        return total;
    endfunction

    function automatic logic source_ready(input int src);
        return (src == 4) ? chain_ready : column_ready[src];
    endfunction

    // Called at edge plus 1 ns, returns at transfer edge plus 1 ns
    task automatic send(input int src, input logic [30:0] word, output bit accepted);
        int waited;
        waited = 0;
        if (src == 4) begin
            chain_data  = word;
            chain_valid = 1'b1;
        end else begin
            column_data[src]  = word;
            column_valid[src] = 1'b1;
        end
        @(negedge clk);
        while (!source_ready(src) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        accepted = source_ready(src);
        if (!accepted) begin
            other_errors++;
            $display("timeout waiting for input ready on source %0d", src);
        end
        @(posedge clk);
        #1;
        chain_valid  = 1'b0;
        column_valid = '0;
    endtask

    // ==========================================================
    // Stimulus
    // ==========================================================

    initial begin
        int              fd;
        int              count;
        int              src;
        int              stall;
        int              col;
        int              slot;
        int              waited;
        int unsigned     seed;
        logic [30:0]     word;
        logic [7:0]      kind;
        logic [7:0]      value;
        logic [8*96-1:0] line;
        bit              accepted;

        seed = 32'hdc75_a695;
        void'($urandom(seed));
        clk          = 1'b0;
        rst_n        = 1'b0;
        column_data  = '0;
        column_valid = '0;
        chain_data   = '0;
        chain_valid  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        @(negedge clk);
        compare("o_outputs", '0, outputs);
        compare("o_host_valid", 1'b0, host_valid);
        compare("o_idle", 1'b1, idle);

        fd = $fopen("nx_aggregator_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the pattern file");
        end else begin
            @(posedge clk);
            #1;
            while (!$feof(fd)) begin
                line = '0;
                void'($fgets(line, fd));
                count = $sscanf(line, "%d %h %d %s %d %d %h",
                                src, word, stall, kind, col, slot, value);
                if (count == 7) begin
                    stall_until = cycle_count + stall;
                    send(src, word, accepted);
                    if (accepted && kind == "F") begin
                        pending[src].push_back(word);
                    end
                    // Masked byte merge, data in 17:10, mask in 9:2
                    if (accepted && kind == "C") begin
                        model[col][slot] = (word[17:10] & word[9:2])
                                         | (model[col][slot] & ~word[9:2]);
                    end
                    @(negedge clk);
                    compare("o_outputs", model, outputs);
                    if (kind == "C") begin
                        compare("o_outputs slot", value, outputs[col*32 + slot*8 +: 8]);
                    end
                    repeat ($urandom % 3) @(posedge clk);
                    @(posedge clk);
                    #1;
                end
            end
            $fclose(fd);
        end

        // Drain with the host always ready
        stall_until = 0;
        waited = 0;
        while (pending_total() > 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pending_total() > 0) begin
            other_errors++;
            $display("timeout waiting for host output, %0d words missing", pending_total());
        end
        waited = 0;
        while (!idle && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!idle) begin
            other_errors++;
            $display("timeout waiting for the chain to go idle");
        end

        assertion_errors = UUT.gen_column[0].u_aggregator.u_checker.failures
                         + UUT.gen_column[1].u_aggregator.u_checker.failures
                         + UUT.gen_column[2].u_aggregator.u_checker.failures
                         + UUT.gen_column[3].u_aggregator.u_checker.failures;
        $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
                 checks, value_errors, other_errors, assertion_errors);
        if (value_errors == 0 && other_errors == 0 && assertion_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_nx_aggregator_chain

`default_nettype wire
